/* board_pkg.sv */
package board_pkg;

	// ==============================
	// axi bus geometry
	// ==============================
	localparam int axi_id_w   = 12;	// hps-to-fpga bridge id width
	localparam int axi_addr_w = 30;	// byte address
	localparam int axi_data_w = 32;
	localparam int axi_strb_w = axi_data_w / 8;	// one strobe per byte

	// ==============================
	// register map
	// ==============================
	localparam logic [axi_addr_w-1:0] reg_version_addr = 'h00;	// ro, version word
	localparam logic [axi_addr_w-1:0] reg_switch_addr  = 'h04;	// ro, slide switches
	localparam logic [axi_addr_w-1:0] reg_led_addr     = 'h08;	// rw, led[4:2]
	localparam logic [axi_addr_w-1:0] reg_jp3_addr     = 'h0C;	// rw, on-board header
	localparam logic [axi_addr_w-1:0] reg_jp5_addr     = 'h10;	// rw, 20-pin header
	localparam logic [axi_addr_w-1:0] reg_jp4_addr     = 'h14;	// rw, last mapped word
	localparam int reg_idx_w = 3;	// word index bits, addr[4:2]

	// version fields
	localparam logic [7:0]  fpga_dev_id = 8'h02;
	localparam logic [7:0]  fpga_fun_id = 8'h01;
	localparam logic [15:0] fpga_rev_id = 16'h0001;

	// axi response codes
	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// ==============================
	// pins and heartbeat
	// ==============================
	localparam int n_switch   = 4;	// sw[4:1], active low
	localparam int n_led_reg  = 3;	// led[4:2], led[1] is heartbeat
	localparam int n_jp3      = 4;
	localparam int n_jp5      = 20;
	localparam int n_jp4_lane = 6;	// per diff-pair leg, driven single ended

	localparam int         hb_top_w   = 4;	// decoded counter msbs
	localparam logic [3:0] hb_phase_a = 4'd0;	// first blink
	localparam logic [3:0] hb_phase_b = 4'd2;	// second blink

	// axi channel payloads
	typedef struct packed {
		logic [axi_id_w-1:0]   awid;
		logic [axi_addr_w-1:0] awaddr;
	} axi_aw_t;

	typedef struct packed {
		logic [axi_data_w-1:0] wdata;
		logic [axi_strb_w-1:0] wstrb;
	} axi_w_t;

	typedef struct packed {
		logic [axi_id_w-1:0] bid;
		logic [1:0]          bresp;
	} axi_b_t;

	typedef struct packed {
		logic [axi_id_w-1:0]   arid;
		logic [axi_addr_w-1:0] araddr;
	} axi_ar_t;

	typedef struct packed {
		logic [axi_id_w-1:0]   rid;
		logic [axi_data_w-1:0] rdata;
		logic [1:0]            rresp;
	} axi_r_t;

	// jp4 header, 24 pins in register bit order
	typedef struct packed {
		logic [n_jp4_lane-1:0] rxn;	// bits 23:18
		logic [n_jp4_lane-1:0] rxp;
		logic [n_jp4_lane-1:0] txn;
		logic [n_jp4_lane-1:0] txp;	// bits 5:0
	} jp4_pins_t;

	// version word, raw bus view or field view
	typedef union packed {
		logic [axi_data_w-1:0] raw;
		struct packed {
			logic [7:0]  dev;
			logic [7:0]  fun;
			logic [15:0] rev;
		} f;
	} fpga_version_u;

endpackage

/* switch_sync.sv */
`timescale 1ns/100ps

module switch_sync
	import board_pkg::*;
(
	input  logic                axi_clk,
	input  logic                reset,
	input  logic [n_switch-1:0] sw_pin,	// raw pins, active low
	output logic [n_switch-1:0] sw_state	// 1 = switch on
);

	logic [n_switch-1:0] sw_meta;	// first stage, may go metastable

	// invert on entry so a cleared stage reads as all off
	always_ff @(posedge axi_clk)
	begin
		if (reset)
		begin
			sw_meta  <= '0;
			sw_state <= '0;
		end
		else
		begin
			sw_meta  <= ~sw_pin;
			sw_state <= sw_meta;	// second stage
		end
	end

endmodule

/* heartbeat_gen.sv */
`timescale 1ns/100ps

module heartbeat_gen
	import board_pkg::*;
#(
	parameter int hb_lsb = 23	// 2^hb_lsb cycles per phase
)
(
	input  logic axi_clk,
	input  logic reset,
	output logic hb_led
);

	logic [hb_top_w+hb_lsb-1:0] hb_cnt;	// free running
	logic [hb_top_w-1:0]        hb_phase;	// 16 phases per period

	assign hb_phase = hb_cnt[hb_top_w+hb_lsb-1:hb_lsb];

	always_ff @(posedge axi_clk)
	begin
		if (reset)
			hb_cnt <= '0;
		else
			hb_cnt <= hb_cnt + 1'b1;	// wraps
	end

	// double blink, on in phases 0 and 2, dark for the rest
	always_ff @(posedge axi_clk)
	begin
		if (reset)
			hb_led <= 1'b0;
		else
			hb_led <= (hb_phase == hb_phase_a) || (hb_phase == hb_phase_b);
	end

endmodule

/* board_regs.sv */
`timescale 1ns/100ps

module board_regs
	import board_pkg::*;
(
	input  logic                 axi_clk,
	input  logic                 reset,
	input  axi_aw_t              aw,
	input  logic                 awvalid,
	output logic                 awready,
	input  axi_w_t               w,
	input  logic                 wvalid,
	output logic                 wready,
	output axi_b_t               b,
	output logic                 bvalid,
	input  logic                 bready,
	input  axi_ar_t              ar,
	input  logic                 arvalid,
	output logic                 arready,
	output axi_r_t               r,
	output logic                 rvalid,
	input  logic                 rready,
	input  logic [n_switch-1:0]  switches,
	output logic [n_led_reg-1:0] led_ctrl,
	output logic [n_jp3-1:0]     jp3_out,
	output logic [n_jp5-1:0]     jp5_out,
	output jp4_pins_t            jp4_out
);

	localparam int jp4_w = $bits(jp4_pins_t);

	fpga_version_u         ver;	// constant version word
	logic [axi_data_w-1:0] reg_word [2**reg_idx_w];	// read view of every word slot
	logic                  wr_fire;	// aw and w taken together
	logic                  rd_fire;
	logic                  aw_hit;
	logic                  ar_hit;
	logic [axi_data_w-1:0] wr_old;	// current value of addressed reg
	logic [axi_data_w-1:0] wr_new;	// after byte strobes

	// mapped means word aligned and not past jp4
	function automatic logic addr_hit(input logic [axi_addr_w-1:0] addr);
		return (addr[1:0] == 2'b00) && (addr <= reg_jp4_addr);
	endfunction

	function automatic logic [reg_idx_w-1:0] reg_idx(input logic [axi_addr_w-1:0] addr);
		return addr[reg_idx_w+1:2];
	endfunction

	// replace only the strobed bytes
	function automatic logic [axi_data_w-1:0] merge_strb(
		input logic [axi_data_w-1:0] old_word,
		input logic [axi_data_w-1:0] new_word,
		input logic [axi_strb_w-1:0] strb
	);
		logic [axi_data_w-1:0] res;
		res = old_word;
		for (int i = 0; i < axi_strb_w; i++)
		begin
			if (strb[i])
				res[i*8 +: 8] = new_word[i*8 +: 8];
		end
		return res;
	endfunction

	// ==============================
	// register read view
	// ==============================
	always_comb
	begin
		ver.f.dev = fpga_dev_id;
		ver.f.fun = fpga_fun_id;
		ver.f.rev = fpga_rev_id;
	end

	always_comb
	begin
		for (int i = 0; i < 2**reg_idx_w; i++)
			reg_word[i] = '0;	// holes read zero
		reg_word[reg_idx(reg_version_addr)] = ver.raw;
		reg_word[reg_idx(reg_switch_addr)]  = {{(axi_data_w-n_switch){1'b0}}, switches};
		reg_word[reg_idx(reg_led_addr)]     = {{(axi_data_w-n_led_reg){1'b0}}, led_ctrl};
		reg_word[reg_idx(reg_jp3_addr)]     = {{(axi_data_w-n_jp3){1'b0}}, jp3_out};
		reg_word[reg_idx(reg_jp5_addr)]     = {{(axi_data_w-n_jp5){1'b0}}, jp5_out};
		reg_word[reg_idx(reg_jp4_addr)]     = {{(axi_data_w-jp4_w){1'b0}}, jp4_out};
	end

	// ==============================
	// write channel
	// ==============================
	assign wr_fire = awvalid & wvalid & ~bvalid;	// no new write while b pending
	assign awready = wr_fire;	// address and data taken together
	assign wready  = wr_fire;
	assign aw_hit  = addr_hit(aw.awaddr);
	assign wr_old  = aw_hit ? reg_word[reg_idx(aw.awaddr)] : '0;
	assign wr_new  = merge_strb(wr_old, w.wdata, w.wstrb);

	always_ff @(posedge axi_clk)
	begin
		if (reset)
		begin
			led_ctrl <= '0;
			jp3_out  <= '0;
			jp5_out  <= '0;
			jp4_out  <= '0;
		end
		else if (wr_fire)
		begin
			case (aw.awaddr)	// full compare, unaligned never matches
				reg_led_addr: led_ctrl <= wr_new[n_led_reg-1:0];
				reg_jp3_addr: jp3_out  <= wr_new[n_jp3-1:0];
				reg_jp5_addr: jp5_out  <= wr_new[n_jp5-1:0];
				reg_jp4_addr: jp4_out  <= wr_new[jp4_w-1:0];
				default: ;	// version, switch, unmapped dropped
			endcase
		end
	end

	always_ff @(posedge axi_clk)
	begin
		if (reset)
			bvalid <= 1'b0;
		else if (wr_fire)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;	// response taken
	end

	always_ff @(posedge axi_clk)
	begin
		if (wr_fire)
		begin
			b.bid   <= aw.awid;	// echo id
			b.bresp <= aw_hit ? resp_okay : resp_slverr;
		end
	end

	// ==============================
	// read channel
	// ==============================
	assign rd_fire = arvalid & ~rvalid;
	assign arready = ~rvalid;	// one read in flight
	assign ar_hit  = addr_hit(ar.araddr);

	always_ff @(posedge axi_clk)
	begin
		if (reset)
			rvalid <= 1'b0;
		else if (rd_fire)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge axi_clk)
	begin
		if (rd_fire)
		begin
			r.rid   <= ar.arid;
			r.rdata <= ar_hit ? reg_word[reg_idx(ar.araddr)] : '0;	// zero on error
			r.rresp <= ar_hit ? resp_okay : resp_slverr;
		end
	end

endmodule

/* board_ctrl_top.sv */
`timescale 1ns/100ps

module board_ctrl_top
	import board_pkg::*;
#(
	parameter int hb_lsb = 23	// lower in simulation for a fast blink
)
(
	input  logic                 axi_clk,
	input  logic                 reset,
	// ==============================
	// hps-to-fpga axi slave
	// ==============================
	input  axi_aw_t              aw,
	input  logic                 awvalid,
	output logic                 awready,
	input  axi_w_t               w,
	input  logic                 wvalid,
	output logic                 wready,
	output axi_b_t               b,
	output logic                 bvalid,
	input  logic                 bready,
	input  axi_ar_t              ar,
	input  logic                 arvalid,
	output logic                 arready,
	output axi_r_t               r,
	output logic                 rvalid,
	input  logic                 rready,
	// ==============================
	// board pins
	// ==============================
	input  logic [n_switch:1]    fpga_sw,	// slide switches, active low
	output logic [n_led_reg+1:1] fpga_led,	// led[1] heartbeat
	output logic [n_jp3:1]       fpga_gpio,	// jp3 header
	output logic [n_jp5:1]       jp5,
	output jp4_pins_t            jp4
);

	logic [n_switch-1:0]  sw_state;
	logic [n_led_reg-1:0] led_ctrl;
	logic                 hb_led;

	board_regs u_regs (
		.axi_clk  (axi_clk),
		.reset    (reset),
		.aw       (aw),
		.awvalid  (awvalid),
		.awready  (awready),
		.w        (w),
		.wvalid   (wvalid),
		.wready   (wready),
		.b        (b),
		.bvalid   (bvalid),
		.bready   (bready),
		.ar       (ar),
		.arvalid  (arvalid),
		.arready  (arready),
		.r        (r),
		.rvalid   (rvalid),
		.rready   (rready),
		.switches (sw_state),
		.led_ctrl (led_ctrl),
		.jp3_out  (fpga_gpio),	// straight to header pins
		.jp5_out  (jp5),
		.jp4_out  (jp4)
	);

	switch_sync u_sw (
		.axi_clk  (axi_clk),
		.reset    (reset),
		.sw_pin   (fpga_sw),
		.sw_state (sw_state)
	);

	heartbeat_gen #(
		.hb_lsb (hb_lsb)
	) u_hb (
		.axi_clk (axi_clk),
		.reset   (reset),
		.hb_led  (hb_led)
	);

	assign fpga_led = {led_ctrl, hb_led};	// led[4:2] from register, led[1] blinks

endmodule

/* board_ctrl_properties.sv */
`timescale 1ns/100ps

module board_ctrl_properties
	import board_pkg::*;
(
	input logic   axi_clk,
	input logic   reset,
	input logic   awready,
	input axi_b_t b,
	input logic   bvalid,
	input logic   bready,
	input axi_r_t r,
	input logic   rvalid,
	input logic   rready
);

	// ==============================
	// responses hold until taken
	// ==============================
	b_hold: assert property (@(posedge axi_clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(b))
		else $error("write response dropped or changed before bready");

	r_hold: assert property (@(posedge axi_clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(r))
		else $error("read data dropped or changed before rready");

	// single write outstanding
	aw_block: assert property (@(posedge axi_clk) disable iff (reset) !(awready && bvalid))
		else $error("awready high while bvalid pending");

endmodule

bind board_regs board_ctrl_properties u_props (
	.axi_clk (axi_clk),
	.reset   (reset),
	.awready (awready),
	.b       (b),
	.bvalid  (bvalid),
	.bready  (bready),
	.r       (r),
	.rvalid  (rvalid),
	.rready  (rready)
);

/* tb_board_ctrl.sv */
`timescale 1ns/100ps

module tb_board_ctrl
	import board_pkg::*;
();

	localparam int clk_half = 50;	// 100 ns period
	localparam int hb_win   = 64;	// heartbeat period at hb_lsb 2

	logic        axi_clk;
	logic        reset;
	axi_aw_t     aw;
	logic        awvalid;
	logic        awready;
	axi_w_t      w;
	logic        wvalid;
	logic        wready;
	axi_b_t      b;
	logic        bvalid;
	logic        bready;
	axi_ar_t     ar;
	logic        arvalid;
	logic        arready;
	axi_r_t      r;
	logic        rvalid;
	logic        rready;
	logic [4:1]  fpga_sw;
	logic [4:1]  fpga_led;
	logic [4:1]  fpga_gpio;
	logic [20:1] jp5;
	jp4_pins_t   jp4;

	// one entry per data file line
	string       t_name [$];
	string       t_op [$];
	logic [31:0] t_addr [$];
	logic [31:0] t_data [$];
	logic [3:0]  t_strb [$];
	logic [1:0]  t_resp [$];
	logic [31:0] t_exp [$];

	logic        hb_samp [2*hb_win];	// led[1] after each edge past reset
	logic        hb_done;
	int          test_err;	// errors in the running test
	int          fail_cnt;
	logic [31:0] lcg_state;

	board_ctrl_top #(.hb_lsb(2)) dut0 (.*);

	initial
	begin
		axi_clk = 1'b0;
		forever
			#clk_half axi_clk = ~axi_clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [50:0] all_pins();
		return {fpga_led[4:2], fpga_gpio, jp5, jp4};	// every register driven pin
	endfunction

	// zero extended pins behind one writable register
	function automatic logic [31:0] pin_value(input logic [31:0] addr);
		case (addr)
			32'h08: return {29'd0, fpga_led[4:2]};
			32'h0c: return {28'd0, fpga_gpio};
			32'h10: return {12'd0, jp5};
			32'h14: return {8'd0, jp4};
			default: return 32'd0;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("ERR %s: expected %h, actual %h", name, exp, act);
		test_err++;
	endtask

	task automatic report_problem(input string name, input string msg);
		$display("%s: %s", name, msg);
		test_err++;
	endtask

	// ==============================
	// data file and background tasks
	// ==============================
	task automatic load_tests();
		int          fd;
		int          n;
		string       line;
		string       name;
		string       op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] strb;
		logic [31:0] resp;
		logic [31:0] exp;
		fd = $fopen("board_input.txt", "r");
		if (fd == 0)
		begin
			$display("cannot open the stimulus file board_input.txt");
			fail_cnt++;
			return;
		end
		while ($fgets(line, fd) != 0)
		begin
			if (line.len() < 4 || line.getc(0) == "#")
				continue;	// header or blank
			n = $sscanf(line, "%s %s %h %h %h %h %h", name, op, addr, data, strb, resp, exp);
			if (n == 7)
			begin
				t_name.push_back(name);
				t_op.push_back(op);
				t_addr.push_back(addr);
				t_data.push_back(data);
				t_strb.push_back(strb[3:0]);
				t_resp.push_back(resp[1:0]);
				t_exp.push_back(exp);
			end
		end
		$fclose(fd);
	endtask

	task automatic watchdog(input int n_lines);
		repeat (n_lines * 20 + 200) @(posedge axi_clk);
		$display("watchdog expired, the run did not finish in time");
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic capture_heartbeat();
		@(negedge reset);
		@(posedge axi_clk);	// first counting edge
		for (int i = 0; i < 2*hb_win; i++)
		begin
			@(negedge axi_clk);
			hb_samp[i] = fpga_led[1];
		end
		hb_done = 1'b1;
	endtask

	// ==============================
	// axi master
	// ==============================
	task automatic offer_write(input logic [31:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input logic [11:0] id);
		@(posedge axi_clk);
		aw      <= '{awid: id, awaddr: addr[axi_addr_w-1:0]};
		w       <= '{wdata: data, wstrb: strb};
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
	endtask

	task automatic finish_write(input string name, output axi_b_t resp);
		do
		begin
			@(negedge axi_clk);
			if (awready !== wready)
				report_problem(name, "awready and wready differ on a write");
		end
		while (!awready);	// taken on next edge
		@(posedge axi_clk);
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do
			@(negedge axi_clk);
		while (!bvalid);
		resp = b;
	endtask

	task automatic axi_read(input logic [31:0] addr, input logic [11:0] id,
		output axi_r_t resp);
		@(posedge axi_clk);
		ar      <= '{arid: id, araddr: addr[axi_addr_w-1:0]};
		arvalid <= 1'b1;
		do
			@(negedge axi_clk);
		while (!arready);
		@(posedge axi_clk);
		arvalid <= 1'b0;
		do
			@(negedge axi_clk);
		while (!rvalid);
		resp = r;	// rready already high
	endtask

	// ==============================
	// one data file line
	// ==============================
	task automatic run_test(input int i);
		axi_b_t        bres;
		axi_r_t        rres;
		fpga_version_u ver_exp;
		fpga_version_u ver_act;
		logic [50:0]   pins_before;
		logic [11:0]   id;
		int            hold;
		int            runs;
		int            len;
		id = 12'h100 + 12'(i);	// distinct per line
		test_err = 0;
		if (t_op[i] == "W")
		begin
			pins_before = all_pins();
			offer_write(t_addr[i], t_data[i], t_strb[i], id);
			finish_write(t_name[i], bres);
			if (bres.bresp !== t_resp[i])
				report_mismatch(t_name[i], 32'(t_resp[i]), 32'(bres.bresp));
			if (bres.bid !== id)
				report_mismatch(t_name[i], 32'(id), 32'(bres.bid));
			if (t_resp[i] == resp_okay && t_addr[i] >= 32'h08)
			begin
				if (pin_value(t_addr[i]) !== t_exp[i])
					report_mismatch(t_name[i], t_exp[i], pin_value(t_addr[i]));
			end
			else if (all_pins() !== pins_before)
				report_problem(t_name[i], "pins changed on an ignored write");
		end
		else if (t_op[i] == "R")
		begin
			axi_read(t_addr[i], id, rres);
			if (rres.rresp !== t_resp[i])
				report_mismatch(t_name[i], 32'(t_resp[i]), 32'(rres.rresp));
			if (rres.rdata !== t_exp[i])
				report_mismatch(t_name[i], t_exp[i], rres.rdata);
			if (rres.rid !== id)
				report_mismatch(t_name[i], 32'(id), 32'(rres.rid));
			if (t_addr[i] == 32'h00)	// version fields one by one
			begin
				ver_exp.raw = t_exp[i];
				ver_act.raw = rres.rdata;
				if (ver_act.f.dev !== ver_exp.f.dev)
					report_mismatch(t_name[i], 32'(ver_exp.f.dev), 32'(ver_act.f.dev));
				if (ver_act.f.fun !== ver_exp.f.fun)
					report_mismatch(t_name[i], 32'(ver_exp.f.fun), 32'(ver_act.f.fun));
				if (ver_act.f.rev !== ver_exp.f.rev)
					report_mismatch(t_name[i], 32'(ver_exp.f.rev), 32'(ver_act.f.rev));
			end
		end
		else if (t_op[i] == "S")
		begin
			@(posedge axi_clk);
			fpga_sw <= t_data[i][3:0];
			repeat (3) @(posedge axi_clk);	// two sync stages plus margin
		end
		else if (t_op[i] == "B")
		begin
			lcg_state = lcg_next(lcg_state);
			hold = int'(lcg_state[18:16]) + 1;	// 1 to 8 cycles
			@(posedge axi_clk);
			bready <= 1'b0;
			offer_write(t_addr[i], t_data[i], t_strb[i], id);
			finish_write(t_name[i], bres);
			if (bres.bid !== id)
				report_mismatch(t_name[i], 32'(id), 32'(bres.bid));
			offer_write(t_addr[i], t_exp[i], 4'hf, id + 12'h800);	// second write waits
			repeat (hold)
			begin
				@(negedge axi_clk);
				if (awready || wready)
					report_problem(t_name[i],
						"second write accepted while a response was pending");
			end
			if (pin_value(t_addr[i]) !== t_data[i])
				report_mismatch(t_name[i], t_data[i], pin_value(t_addr[i]));
			@(posedge axi_clk);
			bready <= 1'b1;
			finish_write(t_name[i], bres);
			if (bres.bid !== id + 12'h800)
				report_mismatch(t_name[i], 32'(id + 12'h800), 32'(bres.bid));
			if (bres.bresp !== t_resp[i])
				report_mismatch(t_name[i], 32'(t_resp[i]), 32'(bres.bresp));
			if (pin_value(t_addr[i]) !== t_exp[i])
				report_mismatch(t_name[i], t_exp[i], pin_value(t_addr[i]));
		end
		else if (t_op[i] == "H")
		begin
			while (!hb_done)
				@(negedge axi_clk);
			for (int wdw = 0; wdw < 2; wdw++)
			begin
				runs = 0;
				len  = 0;
				for (int k = 0; k < hb_win; k++)
				begin
					if (hb_samp[wdw*hb_win + k])
						len++;
					if (len != 0 && (!hb_samp[wdw*hb_win + k] || k == hb_win - 1))
					begin
						runs++;	// run just ended
						if (32'(len) != t_data[i])
							report_mismatch(t_name[i], t_data[i], 32'(len));
						len = 0;
					end
				end
				if (32'(runs) !== t_exp[i])
					report_mismatch(t_name[i], t_exp[i], 32'(runs));
			end
		end
		else
			report_problem(t_name[i], "unknown operation in the data file");
		$display("%s %s", t_name[i], (test_err == 0) ? "pass" : "fail");
		if (test_err != 0)
			fail_cnt++;
	endtask

	initial
	begin
		reset     <= 1'b1;
		aw        <= '0;
		awvalid   <= 1'b0;
		w         <= '0;
		wvalid    <= 1'b0;
		bready    <= 1'b1;
		ar        <= '0;
		arvalid   <= 1'b0;
		rready    <= 1'b1;
		fpga_sw   <= '1;	// all switches off
		hb_done   = 1'b0;
		fail_cnt  = 0;
		test_err  = 0;
		lcg_state = 32'h9673_1dc7;
		load_tests();
		fork
			watchdog(t_name.size());
			capture_heartbeat();
		join_none
		repeat (8) @(posedge axi_clk);
		reset <= 1'b0;
		for (int i = 0; i < t_name.size(); i++)
			run_test(i);
		$display("tests %0d, failed %0d", t_name.size(), fail_cnt);
		if (fail_cnt == 0 && t_name.size() > 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* board_input.txt */
# name op addr data strb resp expdata, numbers in hex
# op W write, R read, S switch pins, B write under bready hold, H heartbeat (data run length, exp runs)
ver_rd R 00 00000000 0 0 02010001
ver_wr W 00 ffffffff f 0 00000000
ver_rd2 R 00 00000000 0 0 02010001
led_wr W 08 00000005 f 0 00000005
led_rd R 08 00000000 0 0 00000005
jp3_wr W 0c 0000000a 1 0 0000000a
jp3_nostrb W 0c 0000000f e 0 0000000a
jp3_rd R 0c 00000000 0 0 0000000a
jp5_wr W 10 000abcde f 0 000abcde
jp5_part W 10 00012345 2 0 000a23de
jp5_rd R 10 00000000 0 0 000a23de
jp4_wr W 14 00ffffff f 0 00ffffff
jp4_part W 14 00123456 5 0 0012ff56
jp4_rd R 14 00000000 0 0 0012ff56
sw_set S 00 00000005 0 0 00000000
sw_rd R 04 00000000 0 0 0000000a
bad_wr W 18 ffffffff f 2 00000000
bad_rd R 18 00000000 0 2 00000000
odd_wr W 02 ffffffff f 2 00000000
odd_rd R 02 00000000 0 2 00000000
hold_wr B 10 00011111 f 0 00022222
hold_rd R 10 00000000 0 0 00022222
hb_chk H 00 00000004 0 0 00000002

/* flist.f */
board_pkg.sv
switch_sync.sv
heartbeat_gen.sv
board_regs.sv
board_ctrl_top.sv
board_ctrl_properties.sv
tb_board_ctrl.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing --assert -Wall
TOP       = tb_board_ctrl
FLIST     = flist.f
SIM       = obj_dir/V$(TOP)
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./$(SIM) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)
